// File: source/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int Xlen = 32;
    localparam int RegAddrW = 5;

    // a0 in the ABI
    localparam logic [RegAddrW-1:0] A0Index = 5'd10;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluSlt = 4'd4
    } aluOpE;

    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2
    } immSrcE;

endpackage

`default_nettype wire

// File: source/programCounter.sv
`default_nettype none

module programCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   pcSrc,
    input  logic [rvPkg::Xlen-1:0] immOp,
    output logic [rvPkg::Xlen-1:0] pc
);
    import rvPkg::*;

    logic [Xlen-1:0] pcNext;

    // Branch target is relative to the branch itself
    assign pcNext = pcSrc ? pc + immOp : pc + Xlen'(4);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: source/instrMem.sv
`default_nettype none

module instrMem #(
    parameter int IMemWords = 256
) (
    input  logic                         clk,
    input  logic [rvPkg::Xlen-1:0]       pc,
    output logic [rvPkg::Xlen-1:0]       instr,
    input  logic                         progWe,
    input  logic [$clog2(IMemWords)-1:0] progAddr,
    input  logic [rvPkg::Xlen-1:0]       progData
);
    import rvPkg::*;

    localparam int AddrW = $clog2(IMemWords);

    logic [Xlen-1:0] mem [IMemWords];
    logic [Xlen-1:0] wordIdx;

    assign wordIdx = pc >> 2;

    // Out of range fetches return zero, which decodes as a no-op
    assign instr = (wordIdx < IMemWords) ? mem[wordIdx[AddrW-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`default_nettype none

module controlUnit (
    input  logic [rvPkg::Xlen-1:0] instr,
    input  logic                   eq,
    output logic                   regWrite,
    output logic                   memWrite,
    output logic                   resultSrc,
    output logic                   aluSrc,
    output rvPkg::aluOpE           aluOp,
    output rvPkg::immSrcE          immSrc,
    output logic                   pcSrc
);
    import rvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode = opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb begin
        // Unknown encodings fall through as a no-op
        regWrite = 1'b0;
        memWrite = 1'b0;
        resultSrc = 1'b0;
        aluSrc = 1'b0;
        aluOp = aluAdd;
        immSrc = immI;
        pcSrc = 1'b0;
        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000: aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b111: aluOp = aluAnd;
                    3'b110: aluOp = aluOr;
                    3'b010: aluOp = aluSlt;
                    default: regWrite = 1'b0;
                endcase
            end
            opImm: begin
                // Only addi in the subset
                regWrite = (funct3 == 3'b000);
                aluSrc = 1'b1;
            end
            opLoad: begin
                regWrite = 1'b1;
                resultSrc = 1'b1;
                aluSrc = 1'b1;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc = 1'b1;
                immSrc = immS;
            end
            opBranch: begin
                aluOp = aluSub;
                immSrc = immB;
                case (funct3)
                    3'b000: pcSrc = eq;
                    3'b001: pcSrc = !eq;
                    default: pcSrc = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/signExtend.sv
`default_nettype none

module signExtend (
    input  logic [rvPkg::Xlen-1:0] instr,
    input  rvPkg::immSrcE          immSrc,
    output logic [rvPkg::Xlen-1:0] immOp
);
    import rvPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            immI: immOp = {{20{sign}}, instr[31:20]};
            immS: immOp = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords
            immB: immOp = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: immOp = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu (
    input  logic [rvPkg::Xlen-1:0] rd1,
    input  logic [rvPkg::Xlen-1:0] rd2,
    input  logic [rvPkg::Xlen-1:0] immOp,
    input  logic                   aluSrc,
    input  rvPkg::aluOpE           aluOp,
    output logic [rvPkg::Xlen-1:0] aluOut,
    output logic                   eq
);
    import rvPkg::*;

    logic [Xlen-1:0] opB;
    logic [Xlen-1:0] diff;
    logic            lessThan;

    assign opB = aluSrc ? immOp : rd2;
    assign diff = rd1 - opB;
    assign lessThan = $signed(rd1) < $signed(opB);

    // Branches compare through the subtractor
    assign eq = (diff == '0);

    always_comb begin
        case (aluOp)
            aluAdd: aluOut = rd1 + opB;
            aluSub: aluOut = diff;
            aluAnd: aluOut = rd1 & opB;
            aluOr:  aluOut = rd1 | opB;
            aluSlt: aluOut = {{(Xlen-1){1'b0}}, lessThan};
            default: aluOut = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [rvPkg::Xlen-1:0] instr,
    input  logic                   regWrite,
    input  logic                   resultSrc,
    input  logic [rvPkg::Xlen-1:0] aluOut,
    input  logic [rvPkg::Xlen-1:0] readData,
    output logic [rvPkg::Xlen-1:0] rd1,
    output logic [rvPkg::Xlen-1:0] rd2,
    output logic [rvPkg::Xlen-1:0] a0
);
    import rvPkg::*;

    logic [Xlen-1:0]     regs [2**RegAddrW];
    logic [RegAddrW-1:0] rs1;
    logic [RegAddrW-1:0] rs2;
    logic [RegAddrW-1:0] rd;
    logic [Xlen-1:0]     result;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    // Load data or ALU result
    assign result = resultSrc ? readData : aluOut;

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];
    assign a0 = regs[A0Index];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin
            regs[rd] <= result;
        end
    end

endmodule

`default_nettype wire

// File: source/dataMem.sv
`default_nettype none

module dataMem #(
    parameter int DMemWords = 64
) (
    input  logic                   clk,
    input  logic [rvPkg::Xlen-1:0] addr,
    input  logic [rvPkg::Xlen-1:0] wd,
    input  logic                   memWrite,
    output logic [rvPkg::Xlen-1:0] readData
);
    import rvPkg::*;

    localparam int AddrW = $clog2(DMemWords);

    logic [Xlen-1:0]  mem [DMemWords];
    logic [AddrW-1:0] wordIdx;

    // Byte offset dropped, upper bits wrap
    assign wordIdx = addr[AddrW+1:2];
    assign readData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[wordIdx] <= wd;
        end
    end

endmodule

`default_nettype wire

// File: source/cpuTop.sv
`default_nettype none

module cpuTop #(
    parameter int IMemWords = 256,
    parameter int DMemWords = 64
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [$clog2(IMemWords)-1:0] progAddr,
    input  logic [rvPkg::Xlen-1:0]       progData,
    output logic [rvPkg::Xlen-1:0]       a0
);
    import rvPkg::*;

    logic [Xlen-1:0] pc;
    logic [Xlen-1:0] instr;
    logic [Xlen-1:0] immOp;
    logic [Xlen-1:0] rd1;
    logic [Xlen-1:0] rd2;
    logic [Xlen-1:0] aluOut;
    logic [Xlen-1:0] readData;

    // Control
    logic   regWrite;
    logic   memWrite;
    logic   resultSrc;
    logic   aluSrc;
    logic   pcSrc;
    logic   eq;
    aluOpE  aluOp;
    immSrcE immSrc;

    programCounter programCounterInst (
        .clk   (clk),
        .rstN  (rstN),
        .pcSrc (pcSrc),
        .immOp (immOp),
        .pc    (pc)
    );

    instrMem #(
        .IMemWords (IMemWords)
    ) instrMemInst (
        .clk      (clk),
        .pc       (pc),
        .instr    (instr),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData)
    );

    controlUnit controlUnitInst (
        .instr     (instr),
        .eq        (eq),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .resultSrc (resultSrc),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .immSrc    (immSrc),
        .pcSrc     (pcSrc)
    );

    signExtend signExtendInst (
        .instr  (instr),
        .immSrc (immSrc),
        .immOp  (immOp)
    );

    alu aluInst (
        .rd1    (rd1),
        .rd2    (rd2),
        .immOp  (immOp),
        .aluSrc (aluSrc),
        .aluOp  (aluOp),
        .aluOut (aluOut),
        .eq     (eq)
    );

    regFile regFileInst (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .regWrite  (regWrite),
        .resultSrc (resultSrc),
        .aluOut    (aluOut),
        .readData  (readData),
        .rd1       (rd1),
        .rd2       (rd2),
        .a0        (a0)
    );

    dataMem #(
        .DMemWords (DMemWords)
    ) dataMemInst (
        .clk      (clk),
        .addr     (aluOut),
        .wd       (rd2),
        .memWrite (memWrite),
        .readData (readData)
    );

endmodule

`default_nettype wire

// File: tests/cpuTop_sva.sv
`default_nettype none

module cpuTopSva (
    input logic                   clk,
    input logic                   rstN,
    input logic [rvPkg::Xlen-1:0] pc,
    input logic [rvPkg::Xlen-1:0] a0,
    input logic                   memWrite,
    input logic                   regWrite,
    input logic                   resultSrc
);
    timeunit 1ns;
    timeprecision 1ps;

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned: %h", pc);

    pcInReset: assert property (@(posedge clk) !rstN |-> pc == '0)
        else $error("pc is not zero while reset is held: %h", pc);

    // Registers are cleared and no instruction retires
    a0InReset: assert property (@(posedge clk) ($past(!rstN) && !rstN) |-> $stable(a0))
        else $error("a0 changed while reset is held");

    // A load writes a register, never memory
    loadNoStore: assert property (@(posedge clk) disable iff (!rstN)
        !(memWrite && regWrite && resultSrc))
        else $error("memWrite and regWrite both set with load result selected");

endmodule

bind cpuTop cpuTopSva cpuTopSvaInst (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .a0        (a0),
    .memWrite  (memWrite),
    .regWrite  (regWrite),
    .resultSrc (resultSrc)
);

`default_nettype wire

// File: tests/cpuTb.sv
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;
    import rvPkg::*;

    localparam int IMemWords = 256;
    localparam int DMemWords = 64;
    localparam int AddrW = $clog2(IMemWords);
    localparam int ProgLen = 41;
    localparam int ResetCycles = 16;
    localparam int NumTests = 7;
    localparam int TestCycles = 2 * ProgLen + ResetCycles + 8;
    localparam logic [Xlen-1:0] DonePc = (ProgLen - 1) * 4;

    localparam int KindArith = 0;
    localparam int KindZero = 1;
    localparam int KindMem = 2;
    localparam int KindBranch = 3;
    localparam int KindReset = 4;
    localparam int KindUnknown = 5;

    localparam int ClsArith = 0;
    localparam int ClsZero = 1;
    localparam int ClsBranch = 2;
    localparam int ClsMem = 3;
    localparam int ClsUnknown = 4;

    logic                 clk;
    logic                 rstN;
    logic                 progWe;
    logic [AddrW-1:0]     progAddr;
    logic [Xlen-1:0]      progData;
    logic [Xlen-1:0]      a0;

    logic [Xlen-1:0] prog [ProgLen];
    logic [Xlen-1:0] modelRegs [32];
    logic [Xlen-1:0] modelMem [DMemWords];
    logic [Xlen-1:0] modelPc;
    int passed;
    int failed;
    int errors;

    cpuTop #(
        .IMemWords (IMemWords),
        .DMemWords (DMemWords)
    ) DUT (
        .clk      (clk),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (NumTests * TestCycles * 2) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input int rs2, input int rs1,
                                            input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opReg};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd,
                                            input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] imm, input int rs2, input int rs1,
                                            input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic int randomSrc();
        return ($urandom_range(6) == 0) ? 0 : 5 + $urandom_range(5);
    endfunction

    // Biased toward a0 so most results are visible
    function automatic int randomDst();
        return ($urandom_range(2) == 0) ? 10 : 5 + $urandom_range(4);
    endfunction

    function automatic logic [31:0] randomArith(input int rd);
        int rs1;
        int rs2;
        rs1 = randomSrc();
        rs2 = randomSrc();
        case ($urandom_range(5))
            0: return encodeR(7'h00, rs2, rs1, 3'b000, rd);
            1: return encodeR(7'h20, rs2, rs1, 3'b000, rd);
            2: return encodeR(7'h00, rs2, rs1, 3'b111, rd);
            3: return encodeR(7'h00, rs2, rs1, 3'b110, rd);
            4: return encodeR(7'h00, rs2, rs1, 3'b010, rd);
            default: return encodeI(12'($urandom()), rs1, 3'b000, rd, opImm);
        endcase
    endfunction

    function automatic void genProgram(input int kind);
        int p;
        int r;
        int cls;
        int off;
        int rs1;
        logic [31:0] word;
        logic isTarget [ProgLen];
        foreach (isTarget[i]) begin
            isTarget[i] = 1'b0;
        end
        // Word 0 is fetched throughout reset, so never a store
        prog[0] = encodeI(12'($urandom()), 0, 3'b000, randomDst(), opImm);
        p = 1;
        while (p < ProgLen - 1) begin
            r = $urandom_range(9);
            case (kind)
                KindZero: cls = (r < 5) ? ClsZero : ClsArith;
                KindMem: cls = (r < 6) ? ClsMem : ClsArith;
                KindBranch: cls = (r < 4) ? ClsBranch : ClsArith;
                KindReset: cls = (r < 2) ? ClsBranch : ((r < 4) ? ClsMem : ClsArith);
                KindUnknown: cls = (r < 4) ? ClsUnknown : ((r < 6) ? ClsMem : ClsArith);
                default: cls = ClsArith;
            endcase
            // The load must never be reached without its store
            if (cls == ClsMem && (p + 1 >= ProgLen - 1 || isTarget[p + 1])) begin
                cls = ClsArith;
            end
            case (cls)
                ClsZero: begin
                    if ($urandom_range(1) == 1) begin
                        prog[p] = randomArith(0);
                    end else begin
                        prog[p] = encodeR(7'h00, 0, 0, 3'b000, A0Index);
                    end
                end
                ClsBranch: begin
                    off = 1 + $urandom_range(4);
                    if (p + off > ProgLen - 1) begin
                        off = ProgLen - 1 - p;
                    end
                    rs1 = randomSrc();
                    prog[p] = encodeB(13'(off * 4), ($urandom_range(1) == 1) ? rs1 : randomSrc(),
                                      rs1, ($urandom_range(1) == 1) ? 3'b000 : 3'b001);
                    isTarget[p + off] = 1'b1;
                end
                ClsMem: begin
                    off = 4 * $urandom_range(7);
                    prog[p] = encodeS(12'(off), randomSrc(), 0);
                    p++;
                    prog[p] = encodeI(12'(off), 0, 3'b010, A0Index, opLoad);
                end
                ClsUnknown: begin
                    word = $urandom();
                    while (word[6:0] inside {opLoad, opImm, opStore, opReg, opBranch}) begin
                        word[6:0] = 7'($urandom());
                    end
                    prog[p] = word;
                end
                default: prog[p] = randomArith(randomDst());
            endcase
            p++;
        end
        prog[ProgLen - 1] = encodeB(13'd0, 0, 0, 3'b000);
    endfunction

    // Reference interpreter for the RV32I subset
    function automatic void modelStep();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        ins = ((modelPc >> 2) < ProgLen) ? prog[modelPc >> 2] : '0;
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        wr = 1'b0;
        res = '0;
        nextPc = modelPc + 4;
        case (ins[6:0])
            opReg: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'b000: res = ins[30] ? a - b : a + b;
                    3'b111: res = a & b;
                    3'b110: res = a | b;
                    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            opImm: begin
                wr = (ins[14:12] == 3'b000);
                res = a + immI;
            end
            opLoad: begin
                wr = 1'b1;
                res = modelMem[((a + immI) >> 2) % DMemWords];
            end
            opStore: modelMem[((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2) % DMemWords] = b;
            opBranch: begin
                if (ins[12] ? (a != b) : (a == b)) begin
                    nextPc = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            modelRegs[ins[11:7]] = res;
        end
        modelPc = nextPc;
    endfunction

    task automatic runTest(input string name, input int kind, input int stopAfter);
        int testErrors;
        int retired;
        logic [Xlen-1:0] loopPc;
        testErrors = 0;
        @(posedge clk);
        // This edge still retires one instruction of the old program
        if (rstN) begin
            modelStep();
        end
        rstN <= 1'b0;
        genProgram(kind);
        for (int i = 0; i < ProgLen + ResetCycles; i++) begin
            progWe <= (i < ProgLen);
            progAddr <= AddrW'(i);
            progData <= (i < ProgLen) ? prog[i] : '0;
            @(negedge clk);
            assert (a0 === '0) else begin
                $display("Mismatch %s: a0 in reset expected %h actual %h", name, 32'h0, a0);
                testErrors++;
            end
            @(posedge clk);
        end
        progWe <= 1'b0;
        rstN <= 1'b1;
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
        retired = 0;
        while (modelPc != DonePc && retired < stopAfter) begin
            @(posedge clk);
            modelStep();
            retired++;
            @(negedge clk);
            assert (a0 === modelRegs[A0Index]) else begin
                $display("Mismatch %s: a0 expected %h actual %h", name, modelRegs[A0Index], a0);
                testErrors++;
            end
        end
        if (modelPc == DonePc) begin
            loopPc = DUT.pc;
            repeat (3) @(negedge clk);
            assert (DUT.pc === loopPc && loopPc === DonePc) else begin
                $display("Mismatch %s: self-loop pc expected %h actual %h then %h",
                         name, DonePc, loopPc, DUT.pc);
                testErrors++;
            end
        end
        errors += testErrors;
        if (testErrors == 0) begin
            passed++;
            $display("Test %s: ok", name);
        end else begin
            failed++;
            $display("Test %s: %0d errors", name, testErrors);
        end
    endtask

    initial begin
        void'($urandom(32'h1ae1_097d));
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        modelPc = '0;
        passed = 0;
        failed = 0;
        errors = 0;
        runTest("arith", KindArith, ProgLen);
        runTest("x0", KindZero, ProgLen);
        runTest("memory", KindMem, ProgLen);
        runTest("branch", KindBranch, ProgLen);
        // Cut short, then the reload test asserts reset mid-program
        runTest("reset_partial", KindReset, 20);
        runTest("reset_reload", KindReset, ProgLen);
        runTest("unknown", KindUnknown, ProgLen);
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/rvPkg.sv
source/programCounter.sv
source/instrMem.sv
source/controlUnit.sv
source/signExtend.sv
source/alu.sv
source/regFile.sv
source/dataMem.sv
source/cpuTop.sv
tests/cpuTop_sva.sv
tests/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
